//--- mips_exec.f
hdl/mips_pkg.sv
hdl/mips_field_decode.sv
hdl/mips_alu.sv
hdl/mips_branch_unit.sv
hdl/mips_commit.sv
hdl/mips_exec_stage.sv
tests/tb_mips_exec_stage.sv

//--- Makefile
# Verilator build and run for the MIPS execute stage testbench

.PHONY: all run clean

all: run

obj_dir/Vtb_mips_exec_stage: mips_exec.f $(wildcard hdl/*.sv) tests/tb_mips_exec_stage.sv
	verilator --binary --timing -f mips_exec.f --top-module tb_mips_exec_stage

run: obj_dir/Vtb_mips_exec_stage
	out="$$(./obj_dir/Vtb_mips_exec_stage)"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

//--- tests/tb_mips_exec_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the MIPS execute stage
// Applies a table of instructions back to back and checks every commit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_mips_exec_stage import mips_pkg::*;
();

  localparam logic [31:0] VEC = 32'h8000_0000;

  typedef struct packed {
    logic [WORD_W-1:0]     instr;
    logic [WORD_W-1:0]     rs;
    logic [WORD_W-1:0]     rt;
    logic [PC_W-1:0]       pc;
    logic [PC_W-1:0]       pcn;
    logic                  bd;
    logic                  exl;
    logic                  gwen;
    logic [REG_ADDR_W-1:0] gaddr;
    logic [WORD_W-1:0]     gdata;
    logic                  pwen;
    logic [PC_W-1:0]       pdata;
    logic                  exc;
    logic                  cwen;
    logic [3:0]            code;
    logic                  ewen;
    logic [WORD_W-1:0]     edata;
  } row_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  instr_valid;
  logic [WORD_W-1:0]     instr;
  logic [WORD_W-1:0]     rs_data;
  logic [WORD_W-1:0]     rt_data;
  logic [PC_W-1:0]       pc_crnt;
  logic [PC_W-1:0]       pc_next;
  logic                  cause_bd;
  logic                  exl;
  logic                  greg_wen;
  logic [REG_ADDR_W-1:0] greg_waddr;
  logic [WORD_W-1:0]     greg_wdata;
  logic                  pcreg_wen;
  logic [PC_W-1:0]       pcreg_wdata;
  logic                  exception;
  logic                  cause_wen;
  logic [3:0]            cause_excode;
  logic                  epc_wen;
  logic [WORD_W-1:0]     epc_data;

  row_t rows[$];
  int   checks = 0;
  int   errors = 0;

  mips_exec_stage #(
    .EXCEPT_VEC (VEC)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .pc_crnt      (pc_crnt),
    .pc_next      (pc_next),
    .cause_bd     (cause_bd),
    .exl          (exl),
    .greg_wen     (greg_wen),
    .greg_waddr   (greg_waddr),
    .greg_wdata   (greg_wdata),
    .pcreg_wen    (pcreg_wen),
    .pcreg_wdata  (pcreg_wdata),
    .exception    (exception),
    .cause_wen    (cause_wen),
    .cause_excode (cause_excode),
    .epc_wen      (epc_wen),
    .epc_data     (epc_data)
  );

  initial
  begin
    forever #50 clk = ~clk;
  end

  // Watchdog for the whole run
  initial
  begin
    #200_000;
    $display("Timeout: the run did not reach its end");
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [31:0] r_word(input int rs, input int rt, input int rd,
                                         input int sa, input int fn);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), 6'(fn)};
  endfunction

  function automatic logic [31:0] i_word(input int op, input int rs, input int rt,
                                         input int imm);
    return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] j_word(input int op, input int index);
    return {6'(op), 26'(index)};
  endfunction

  function automatic logic any_enable();
    return ({greg_wen, pcreg_wen, exception, cause_wen, epc_wen} !== 5'b0);
  endfunction

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic alu_row(input logic [31:0] word, input logic [31:0] a,
                         input logic [31:0] b, input int rd, input logic [31:0] expected);
    row_t r;
    r       = '0;
    r.instr = word;
    r.rs    = a;
    r.rt    = b;
    r.pc    = 30'h100;
    r.pcn   = 30'h101;
    r.gwen  = (rd != 0);  // r0 is never written
    r.gaddr = 5'(rd);
    r.gdata = expected;
    rows.push_back(r);
  endtask

  task automatic branch_row(input logic [31:0] word, input logic [31:0] a,
                            input logic [31:0] b, input logic [PC_W-1:0] pc,
                            input logic tkn, input logic [PC_W-1:0] dest);
    row_t r;
    r       = '0;
    r.instr = word;
    r.rs    = a;
    r.rt    = b;
    r.pc    = pc;
    r.pcn   = pc + 30'd1;
    r.pwen  = tkn;
    r.pdata = dest;
    rows.push_back(r);
  endtask

  task automatic link_row(input logic [31:0] word, input logic [31:0] a,
                          input logic [PC_W-1:0] pc, input logic [PC_W-1:0] dest,
                          input int rd, input logic [31:0] link);
    row_t r;
    r       = '0;
    r.instr = word;
    r.rs    = a;
    r.pc    = pc;
    r.pcn   = pc + 30'd1;
    r.pwen  = 1'b1;
    r.pdata = dest;
    r.gwen  = 1'b1;
    r.gaddr = 5'(rd);
    r.gdata = link;
    rows.push_back(r);
  endtask

  task automatic exc_row(input logic [31:0] word, input logic [31:0] a,
                         input logic [31:0] b, input logic bd, input logic lvl,
                         input int code, input logic [31:0] epc);
    row_t r;
    r       = '0;
    r.instr = word;
    r.rs    = a;
    r.rt    = b;
    r.pc    = 30'h100;
    r.pcn   = 30'h101;
    r.bd    = bd;
    r.exl   = lvl;
    r.pwen  = 1'b1;
    r.pdata = VEC[31:2];
    r.exc   = 1'b1;
    r.cwen  = ~lvl;
    r.code  = 4'(code);
    r.ewen  = ~lvl;
    r.edata = epc;
    rows.push_back(r);
  endtask

  task automatic drive_row(input row_t r);
    instr_valid = 1'b1;
    instr       = r.instr;
    rs_data     = r.rs;
    rt_data     = r.rt;
    pc_crnt     = r.pc;
    pc_next     = r.pcn;
    cause_bd    = r.bd;
    exl         = r.exl;
  endtask

  // Data fields only matter when their enable is expected high
  task automatic check_row(input row_t r);
    compare("greg_wen", 32'(greg_wen), 32'(r.gwen));
    if (r.gwen)
    begin
      compare("greg_waddr", 32'(greg_waddr), 32'(r.gaddr));
      compare("greg_wdata", greg_wdata, r.gdata);
    end
    compare("pcreg_wen", 32'(pcreg_wen), 32'(r.pwen));
    if (r.pwen)
      compare("pcreg_wdata", 32'(pcreg_wdata), 32'(r.pdata));
    compare("exception", 32'(exception), 32'(r.exc));
    compare("cause_wen", 32'(cause_wen), 32'(r.cwen));
    if (r.cwen)
      compare("cause_excode", 32'(cause_excode), 32'(r.code));
    compare("epc_wen", 32'(epc_wen), 32'(r.ewen));
    if (r.ewen)
      compare("epc_data", epc_data, r.edata);
  endtask

  task automatic expect_idle();
    compare("greg_wen", 32'(greg_wen), 32'd0);
    compare("pcreg_wen", 32'(pcreg_wen), 32'd0);
    compare("exception", 32'(exception), 32'd0);
    compare("cause_wen", 32'(cause_wen), 32'd0);
    compare("epc_wen", 32'(epc_wen), 32'd0);
  endtask

  task automatic wait_for_idle(input int max_cycles);
    int cyc;
    cyc = 0;
    while (any_enable() && cyc < max_cycles)
    begin
      @(negedge clk);
      cyc++;
    end
    if (any_enable())
    begin
      errors++;
      $display("Enables still high %0d cycles after reset release", max_cycles);
    end
  endtask

  // One row per cycle; row i-1 is visible on the negedge where row i is driven
  task automatic apply_table(input string label);
    int base;
    int i;
    base = errors;
    for (i = 0; i <= rows.size(); i++)
    begin
      @(negedge clk);
      if (i > 0)
        check_row(rows[i-1]);
      if (i < rows.size())
        drive_row(rows[i]);
      else
        instr_valid = 1'b0;
    end
    @(negedge clk);
    expect_idle();  // Cycle with instr_valid low
    $display("Test %s finished: %0d rows, %0d errors", label, rows.size(), errors - base);
    rows.delete();
  endtask

  task automatic load_alu_rows();
    alu_row(r_word(1, 2, 3, 0, 'h20), 5, 7, 3, 12);                          // add
    alu_row(r_word(1, 2, 4, 0, 'h21), 'hffff_ffff, 2, 4, 1);                 // addu wraps
    alu_row(r_word(1, 2, 5, 0, 'h22), 10, 3, 5, 7);                          // sub
    alu_row(r_word(1, 2, 6, 0, 'h23), 3, 10, 6, 'hffff_fff9);                // subu
    alu_row(r_word(1, 2, 7, 0, 'h24), 'hf0f0_1234, 'h0ff0_ff00, 7, 'h00f0_1200);
    alu_row(r_word(1, 2, 8, 0, 'h25), 'hf000_0001, 'h0000_1000, 8, 'hf000_1001);
    alu_row(r_word(1, 2, 9, 0, 'h26), 'haaaa_5555, 'hffff_0000, 9, 'h5555_5555);
    alu_row(r_word(1, 2, 10, 0, 'h27), 'h0f0f_0000, 'h0000_00ff, 10, 'hf0f0_ff00);
    alu_row(r_word(0, 2, 11, 4, 'h00), 0, 3, 11, 'h30);                      // sll
    alu_row(r_word(0, 2, 12, 4, 'h02), 0, 'h8000_0000, 12, 'h0800_0000);     // srl
    alu_row(r_word(0, 2, 13, 4, 'h03), 0, 'h8000_0000, 13, 'hf800_0000);     // sra
    alu_row(r_word(1, 2, 14, 0, 'h04), 'h24, 1, 14, 'h10);                   // sllv, low 5 bits
    alu_row(r_word(1, 2, 15, 0, 'h06), 8, 'hff00_0000, 15, 'h00ff_0000);     // srlv
    alu_row(r_word(1, 2, 16, 0, 'h07), 'h21, 'h8000_0000, 16, 'hc000_0000);  // srav
    alu_row(r_word(1, 2, 17, 0, 'h2a), 'hffff_ffff, 1, 17, 1);               // slt signed
    alu_row(r_word(1, 2, 18, 0, 'h2b), 'hffff_ffff, 1, 18, 0);               // sltu unsigned
    alu_row(i_word('h08, 1, 19, 'hffff), 100, 0, 19, 99);                    // addi
    alu_row(i_word('h09, 1, 20, 1), 'h7fff_ffff, 0, 20, 'h8000_0000);        // addiu
    alu_row(i_word('h0a, 1, 21, 'hfff8), 'hffff_fff0, 0, 21, 1);             // slti
    alu_row(i_word('h0b, 1, 22, 'hffff), 5, 0, 22, 1);                       // sltiu
    alu_row(i_word('h0c, 1, 23, 'hff0f), 'hffff_1234, 0, 23, 'h0000_1204);   // andi
    alu_row(i_word('h0d, 1, 24, 'h8001), 'h1234_0000, 0, 24, 'h1234_8001);   // ori
    alu_row(i_word('h0e, 1, 25, 'h00ff), 'h0000_ffff, 0, 25, 'h0000_ff00);   // xori
    alu_row(i_word('h0f, 0, 26, 'hbeef), 'h1111_1111, 0, 26, 'hbeef_0000);   // lui
    alu_row(r_word(1, 2, 0, 0, 'h21), 4, 5, 0, 9);                           // addu to r0
    alu_row(i_word('h08, 1, 0, 3), 4, 0, 0, 7);                              // addi to r0
  endtask

  task automatic load_branch_rows();
    branch_row(i_word('h04, 1, 2, 'h0010), 5, 5, 30'h100, 1'b1, 30'h111);    // beq
    branch_row(i_word('h04, 1, 2, 'h0010), 5, 6, 30'h100, 1'b0, 30'h0);
    branch_row(i_word('h05, 1, 2, 'hfffc), 5, 6, 30'h100, 1'b1, 30'h0fd);    // bne back
    branch_row(i_word('h05, 1, 2, 'hfffc), 5, 5, 30'h100, 1'b0, 30'h0);
    branch_row(i_word('h06, 1, 0, 'h0010), 0, 0, 30'h100, 1'b1, 30'h111);    // blez
    branch_row(i_word('h06, 1, 0, 'h0010), 1, 0, 30'h100, 1'b0, 30'h0);
    branch_row(i_word('h07, 1, 0, 'h0010), 1, 0, 30'h100, 1'b1, 30'h111);    // bgtz
    branch_row(i_word('h07, 1, 0, 'h0010), 'h8000_0000, 0, 30'h100, 1'b0, 30'h0);
    branch_row(i_word('h01, 1, 0, 'h0010), 'hffff_ffff, 0, 30'h100, 1'b1, 30'h111);
    branch_row(i_word('h01, 1, 0, 'h0010), 0, 0, 30'h100, 1'b0, 30'h0);      // bltz
    branch_row(i_word('h01, 1, 1, 'h0010), 0, 0, 30'h100, 1'b1, 30'h111);    // bgez
    branch_row(i_word('h01, 1, 1, 'h0010), 'hffff_ffff, 0, 30'h100, 1'b0, 30'h0);
    branch_row(j_word('h02, 'h012_3456), 0, 0, 30'h2000_0100, 1'b1, 30'h2012_3456);
    link_row(j_word('h03, 'h012_3456), 0, 30'h2000_0100, 30'h2012_3456, 31, 'h8000_0400);
    branch_row(r_word(31, 0, 0, 0, 'h08), 'h0040_1234, 0, 30'h100, 1'b1, 30'h0010_048d);
    link_row(r_word(9, 0, 17, 0, 'h09), 'h0000_2000, 30'h100, 30'h800, 17, 'h400);
  endtask

  task automatic load_overflow_rows();
    exc_row(r_word(1, 2, 3, 0, 'h20), 'h7fff_ffff, 1, 1'b0, 1'b0, 12, 'h400);  // add
    exc_row(r_word(1, 2, 3, 0, 'h22), 'h8000_0000, 1, 1'b0, 1'b0, 12, 'h400);  // sub
    exc_row(i_word('h08, 1, 4, 'hffff), 'h8000_0000, 0, 1'b0, 1'b0, 12, 'h400);
    exc_row(r_word(1, 2, 3, 0, 'h20), 'h7fff_ffff, 1, 1'b1, 1'b0, 12, 'h3fc);  // Delay slot
  endtask

  task automatic load_reserved_rows();
    exc_row(i_word('h3f, 1, 2, 0), 0, 0, 1'b0, 1'b0, 10, 'h400);     // Unknown opcode
    exc_row(r_word(1, 2, 3, 0, 'h3f), 0, 0, 1'b0, 1'b0, 10, 'h400);  // Unknown function
    exc_row(i_word('h3f, 1, 2, 0), 0, 0, 1'b0, 1'b1, 10, 'h400);     // exl keeps cause, EPC
    exc_row(r_word(1, 2, 3, 0, 'h20), 'h7fff_ffff, 1, 1'b0, 1'b1, 12, 'h400);
  endtask

  task automatic load_random_rows();
    logic [31:0] a;
    logic [31:0] b;
    int          rd;
    int          k;
    for (k = 0; k < 20; k++)
    begin
      a  = $urandom;
      b  = $urandom;
      rd = $urandom_range(31, 1);
      alu_row(r_word(4, 5, rd, 0, 'h21), a, b, rd, a + b);  // addu, modulo 2^32
    end
  endtask

  initial
  begin
    int          base;
    int          cyc;
    int unsigned seed_ret;
    seed_ret    = $urandom(32'h5b2b70a9);
    rst_n       = 1'b0;
    instr_valid = 1'b1;  // A valid add during reset must not commit
    instr       = r_word(1, 2, 3, 0, 'h20);
    rs_data     = 32'd1;
    rt_data     = 32'd2;
    pc_crnt     = 30'h100;
    pc_next     = 30'h101;
    cause_bd    = 1'b0;
    exl         = 1'b0;

    base = errors;
    for (cyc = 0; cyc < 16; cyc++)
      @(negedge clk);
    expect_idle();
    rst_n       = 1'b1;
    instr_valid = 1'b0;
    instr       = j_word('h03, 'h012_3456);  // jal, not valid
    wait_for_idle(8);
    @(negedge clk);
    expect_idle();
    $display("Test reset_and_idle finished: %0d errors", errors - base);

    load_alu_rows();
    apply_table("alu_and_immediates");
    load_random_rows();
    apply_table("random_addu");
    load_branch_rows();
    apply_table("branches_and_jumps");
    load_overflow_rows();
    apply_table("overflow");
    load_reserved_rows();
    apply_table("reserved_and_exl");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/mips_exec_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS execute and branch-decide stage
// Decode, ALU and branch resolution feeding one commit register stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mips_exec_stage import mips_pkg::*;
#(
  parameter logic [31:0] EXCEPT_VEC = 32'h8000_0000
)
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  logic [WORD_W-1:0]     instr,
  input  logic [WORD_W-1:0]     rs_data,
  input  logic [WORD_W-1:0]     rt_data,
  input  logic [PC_W-1:0]       pc_crnt,
  input  logic [PC_W-1:0]       pc_next,
  input  logic                  cause_bd,
  input  logic                  exl,
  output logic                  greg_wen,
  output logic [REG_ADDR_W-1:0] greg_waddr,
  output logic [WORD_W-1:0]     greg_wdata,
  output logic                  pcreg_wen,
  output logic [PC_W-1:0]       pcreg_wdata,
  output logic                  exception,
  output logic                  cause_wen,
  output excode_e               cause_excode,
  output logic                  epc_wen,
  output logic [WORD_W-1:0]     epc_data
);

  alu_mode_e             alu_mode;
  logic [WORD_W-1:0]     alu_a;
  logic [WORD_W-1:0]     alu_b;
  logic [4:0]            shamt;
  branch_e               branch_kind;
  logic [15:0]           branch_offset;
  logic                  writes_reg;
  logic [REG_ADDR_W-1:0] waddr;
  logic                  checks_ov;
  logic                  reserved;
  logic [WORD_W-1:0]     alu_result;
  logic                  overflow;
  logic                  taken;
  logic [PC_W-1:0]       target;
  logic                  link;
  logic [WORD_W-1:0]     link_data;

  mips_field_decode i_decode (
    .instr         (instr),
    .rs_data       (rs_data),
    .rt_data       (rt_data),
    .alu_mode      (alu_mode),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .shamt         (shamt),
    .branch_kind   (branch_kind),
    .branch_offset (branch_offset),
    .writes_reg    (writes_reg),
    .waddr         (waddr),
    .checks_ov     (checks_ov),
    .reserved      (reserved)
  );

  mips_alu i_alu (
    .alu_mode (alu_mode),
    .alu_a    (alu_a),
    .alu_b    (alu_b),
    .shamt    (shamt),
    .result   (alu_result),
    .overflow (overflow)
  );

  mips_branch_unit i_branch (
    .branch_kind   (branch_kind),
    .rs_data       (rs_data),
    .rt_data       (rt_data),
    .branch_offset (branch_offset),
    .jump_index    (instr[25:0]),  // J-type index field
    .pc_crnt       (pc_crnt),
    .pc_next       (pc_next),
    .taken         (taken),
    .target        (target),
    .link          (link),
    .link_data     (link_data)
  );

  mips_commit #(
    .EXCEPT_VEC (EXCEPT_VEC)
  ) i_commit (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .writes_reg   (writes_reg),
    .waddr        (waddr),
    .checks_ov    (checks_ov),
    .reserved     (reserved),
    .alu_result   (alu_result),
    .overflow     (overflow),
    .taken        (taken),
    .target       (target),
    .link         (link),
    .link_data    (link_data),
    .pc_crnt      (pc_crnt),
    .cause_bd     (cause_bd),
    .exl          (exl),
    .greg_wen     (greg_wen),
    .greg_waddr   (greg_waddr),
    .greg_wdata   (greg_wdata),
    .pcreg_wen    (pcreg_wen),
    .pcreg_wdata  (pcreg_wdata),
    .exception    (exception),
    .cause_wen    (cause_wen),
    .cause_excode (cause_excode),
    .epc_wen      (epc_wen),
    .epc_data     (epc_data)
  );

endmodule

//--- hdl/mips_commit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Commit register stage
// Registers the GPR write, the PC write and any overflow or RI exception
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mips_commit import mips_pkg::*;
#(
  parameter logic [31:0] EXCEPT_VEC = 32'h8000_0000
)
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  logic                  writes_reg,
  input  logic [REG_ADDR_W-1:0] waddr,
  input  logic                  checks_ov,
  input  logic                  reserved,
  input  logic [WORD_W-1:0]     alu_result,
  input  logic                  overflow,
  input  logic                  taken,
  input  logic [PC_W-1:0]       target,
  input  logic                  link,
  input  logic [WORD_W-1:0]     link_data,
  input  logic [PC_W-1:0]       pc_crnt,
  input  logic                  cause_bd,
  input  logic                  exl,
  output logic                  greg_wen,
  output logic [REG_ADDR_W-1:0] greg_waddr,
  output logic [WORD_W-1:0]     greg_wdata,
  output logic                  pcreg_wen,
  output logic [PC_W-1:0]       pcreg_wdata,
  output logic                  exception,
  output logic                  cause_wen,
  output excode_e               cause_excode,
  output logic                  epc_wen,
  output logic [WORD_W-1:0]     epc_data
);

  logic            exc;
  logic [PC_W-1:0] epc_word;

  assign exc = instr_valid & (reserved | (checks_ov & overflow));

  // Delay slot exceptions restart at the branch
  assign epc_word = cause_bd ? pc_crnt - PC_W'(1) : pc_crnt;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      greg_wen  <= 1'b0;
      pcreg_wen <= 1'b0;
      exception <= 1'b0;
      cause_wen <= 1'b0;
      epc_wen   <= 1'b0;
    end
    else
    begin
      greg_wen  <= instr_valid & writes_reg & ~exc;
      pcreg_wen <= exc | (instr_valid & taken);
      exception <= exc;
      cause_wen <= exc & ~exl;  // Nested exceptions keep cause and EPC
      epc_wen   <= exc & ~exl;
    end
  end

  always_ff @(posedge clk)
  begin
    greg_waddr   <= waddr;
    greg_wdata   <= link ? link_data : alu_result;
    pcreg_wdata  <= exc ? EXCEPT_VEC[WORD_W-1:2] : target;
    cause_excode <= reserved ? EXC_RI : EXC_OV;
    epc_data     <= {epc_word, 2'b00};
  end

endmodule

//--- hdl/mips_branch_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch and jump unit
// Resolves the branch condition, the new PC and the link value
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mips_branch_unit import mips_pkg::*;
(
  input  branch_e           branch_kind,
  input  logic [WORD_W-1:0] rs_data,
  input  logic [WORD_W-1:0] rt_data,
  input  logic [15:0]       branch_offset,
  input  logic [25:0]       jump_index,
  input  logic [PC_W-1:0]   pc_crnt,
  input  logic [PC_W-1:0]   pc_next,
  output logic              taken,
  output logic [PC_W-1:0]   target,
  output logic              link,
  output logic [WORD_W-1:0] link_data
);

  logic            rs_neg;
  logic            rs_zero;
  logic [PC_W-1:0] bta;
  logic [PC_W-1:0] jta;

  assign rs_neg  = rs_data[WORD_W-1];  // rs is signed for the zero compares
  assign rs_zero = (rs_data == '0);

  assign bta = pc_next + {{(PC_W-16){branch_offset[15]}}, branch_offset};
  assign jta = {pc_crnt[PC_W-1:PC_W-4], jump_index};  // Stays in the 256 MB region

  always_comb
  begin
    taken  = 1'b0;
    target = bta;
    case (branch_kind)
      BR_BEQ:  taken = (rs_data == rt_data);
      BR_BNE:  taken = (rs_data != rt_data);
      BR_BLEZ: taken = rs_neg | rs_zero;
      BR_BGTZ: taken = ~rs_neg & ~rs_zero;
      BR_BLTZ: taken = rs_neg;
      BR_BGEZ: taken = ~rs_neg;
      BR_J, BR_JAL:
      begin
        taken  = 1'b1;
        target = jta;
      end
      BR_JR, BR_JALR:
      begin
        taken  = 1'b1;
        target = rs_data[WORD_W-1:2];
      end
      default: taken = 1'b0;
    endcase
  end

  assign link      = (branch_kind == BR_JAL) | (branch_kind == BR_JALR);
  assign link_data = {pc_crnt, 2'b00};

endmodule

//--- hdl/mips_alu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage ALU
// Arithmetic, logic, shift and compare with signed overflow detection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mips_alu import mips_pkg::*;
(
  input  alu_mode_e         alu_mode,
  input  logic [WORD_W-1:0] alu_a,
  input  logic [WORD_W-1:0] alu_b,
  input  logic [4:0]        shamt,
  output logic [WORD_W-1:0] result,
  output logic              overflow
);

  localparam int MSB = WORD_W - 1;

  logic [WORD_W-1:0] sum;
  logic [WORD_W-1:0] diff;

  assign sum  = alu_a + alu_b;
  assign diff = alu_a - alu_b;

  always_comb
  begin
    case (alu_mode)
      ALU_ADD:  result = sum;
      ALU_SUB:  result = diff;
      ALU_SLL:  result = alu_b << shamt;
      ALU_SRL:  result = alu_b >> shamt;
      ALU_SRA:  result = $signed(alu_b) >>> shamt;
      ALU_AND:  result = alu_a & alu_b;
      ALU_OR:   result = alu_a | alu_b;
      ALU_XOR:  result = alu_a ^ alu_b;
      ALU_NOR:  result = ~(alu_a | alu_b);
      ALU_SLT:  result = {{MSB{1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: result = {{MSB{1'b0}}, alu_a < alu_b};
      ALU_LUI:  result = {alu_b[WORD_W/2-1:0], {(WORD_W/2){1'b0}}};
      default:  result = sum;
    endcase
  end

  // Sign of result leaves the sign of operand a when it should not
  always_comb
  begin
    case (alu_mode)
      ALU_ADD: overflow = (alu_a[MSB] == alu_b[MSB]) & (sum[MSB] != alu_a[MSB]);
      ALU_SUB: overflow = (alu_a[MSB] != alu_b[MSB]) & (diff[MSB] != alu_a[MSB]);
      default: overflow = 1'b0;
    endcase
  end

endmodule

//--- hdl/mips_field_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction field decoder
// Splits the instruction word and produces ALU, branch and write control
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mips_field_decode import mips_pkg::*;
(
  input  logic [WORD_W-1:0]     instr,
  input  logic [WORD_W-1:0]     rs_data,
  input  logic [WORD_W-1:0]     rt_data,
  output alu_mode_e             alu_mode,
  output logic [WORD_W-1:0]     alu_a,
  output logic [WORD_W-1:0]     alu_b,
  output logic [4:0]            shamt,
  output branch_e               branch_kind,
  output logic [15:0]           branch_offset,
  output logic                  writes_reg,
  output logic [REG_ADDR_W-1:0] waddr,
  output logic                  checks_ov,
  output logic                  reserved
);

  localparam logic [4:0] RT_BLTZ = 5'd0;
  localparam logic [4:0] RT_BGEZ = 5'd1;

  opcode_e               opcode;
  func_e                 funct;
  logic [REG_ADDR_W-1:0] f_rt;
  logic [REG_ADDR_W-1:0] f_rd;
  logic [4:0]            f_shamt;
  logic [15:0]           f_imm;
  logic [WORD_W-1:0]     imm_sext;
  logic [WORD_W-1:0]     imm_zext;
  logic                  imm_op;
  logic [REG_ADDR_W-1:0] dest;
  logic                  wr;

  assign opcode   = opcode_e'(instr[31:26]);
  assign f_rt     = instr[20:16];
  assign f_rd     = instr[15:11];
  assign f_shamt  = instr[10:6];
  assign funct    = func_e'(instr[5:0]);
  assign f_imm    = instr[15:0];
  assign imm_sext = {{(WORD_W-16){f_imm[15]}}, f_imm};
  assign imm_zext = {{(WORD_W-16){1'b0}}, f_imm};
  assign imm_op   = (instr[31:29] == 3'b001);  // addi .. lui

  assign branch_offset = f_imm;

  always_comb
  begin
    alu_mode    = ALU_ADD;
    alu_a       = rs_data;
    alu_b       = rt_data;
    shamt       = f_shamt;
    branch_kind = BR_NONE;
    dest        = f_rd;
    wr          = 1'b0;
    checks_ov   = 1'b0;
    reserved    = 1'b0;

    case (opcode)
      OP_RTYPE:
      begin
        wr = 1'b1;
        case (funct)
          FN_SLL:  alu_mode = ALU_SLL;
          FN_SRL:  alu_mode = ALU_SRL;
          FN_SRA:  alu_mode = ALU_SRA;
          FN_SLLV:
          begin
            alu_mode = ALU_SLL;
            shamt    = rs_data[4:0];
          end
          FN_SRLV:
          begin
            alu_mode = ALU_SRL;
            shamt    = rs_data[4:0];
          end
          FN_SRAV:
          begin
            alu_mode = ALU_SRA;
            shamt    = rs_data[4:0];
          end
          FN_JR:
          begin
            branch_kind = BR_JR;
            wr          = 1'b0;
          end
          FN_JALR: branch_kind = BR_JALR;  // Link goes to rd
          FN_ADD:  checks_ov = 1'b1;
          FN_ADDU: alu_mode = ALU_ADD;
          FN_SUB:
          begin
            alu_mode  = ALU_SUB;
            checks_ov = 1'b1;
          end
          FN_SUBU: alu_mode = ALU_SUB;
          FN_AND:  alu_mode = ALU_AND;
          FN_OR:   alu_mode = ALU_OR;
          FN_XOR:  alu_mode = ALU_XOR;
          FN_NOR:  alu_mode = ALU_NOR;
          FN_SLT:  alu_mode = ALU_SLT;
          FN_SLTU: alu_mode = ALU_SLTU;
          default:
          begin
            wr       = 1'b0;
            reserved = 1'b1;
          end
        endcase
      end
      OP_REGIMM:
      begin
        case (f_rt)
          RT_BLTZ: branch_kind = BR_BLTZ;
          RT_BGEZ: branch_kind = BR_BGEZ;
          default: reserved = 1'b1;
        endcase
      end
      OP_J:    branch_kind = BR_J;
      OP_JAL:
      begin
        branch_kind = BR_JAL;
        dest        = LINK_REG;
        wr          = 1'b1;
      end
      OP_BEQ:  branch_kind = BR_BEQ;
      OP_BNE:  branch_kind = BR_BNE;
      OP_BLEZ: branch_kind = BR_BLEZ;
      OP_BGTZ: branch_kind = BR_BGTZ;
      OP_ADDI:  checks_ov = 1'b1;
      OP_ADDIU: alu_mode = ALU_ADD;
      OP_SLTI:  alu_mode = ALU_SLT;
      OP_SLTIU: alu_mode = ALU_SLTU;  // Sign-extended, compared unsigned
      OP_ANDI:  alu_mode = ALU_AND;
      OP_ORI:   alu_mode = ALU_OR;
      OP_XORI:  alu_mode = ALU_XOR;
      OP_LUI:   alu_mode = ALU_LUI;
      default:  reserved = 1'b1;
    endcase

    // Immediate group writes rt; the logical ops and lui zero-extend
    if (imm_op)
    begin
      dest  = f_rt;
      wr    = 1'b1;
      alu_b = instr[28] ? imm_zext : imm_sext;
    end
  end

  assign waddr      = dest;
  assign writes_reg = wr & (dest != '0);

endmodule

//--- hdl/mips_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS execute stage definitions
// Widths, instruction encodings, ALU modes, branch kinds and cause codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mips_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int PC_W       = 30;  // Word address, byte bits dropped

  localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

  // Primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE  = 6'b000000,
    OP_REGIMM = 6'b000001,  // bltz / bgez, selected by rt
    OP_J      = 6'b000010,
    OP_JAL    = 6'b000011,
    OP_BEQ    = 6'b000100,
    OP_BNE    = 6'b000101,
    OP_BLEZ   = 6'b000110,
    OP_BGTZ   = 6'b000111,
    OP_ADDI   = 6'b001000,
    OP_ADDIU  = 6'b001001,
    OP_SLTI   = 6'b001010,
    OP_SLTIU  = 6'b001011,
    OP_ANDI   = 6'b001100,
    OP_ORI    = 6'b001101,
    OP_XORI   = 6'b001110,
    OP_LUI    = 6'b001111
  } opcode_e;

  // R-type function codes, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_SRA  = 6'b000011,
    FN_SLLV = 6'b000100,
    FN_SRLV = 6'b000110,
    FN_SRAV = 6'b000111,
    FN_JR   = 6'b001000,
    FN_JALR = 6'b001001,
    FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001,
    FN_SUB  = 6'b100010,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } func_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_AND,
    ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
  } alu_mode_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ, BR_BLTZ,
    BR_BGEZ, BR_J, BR_JAL, BR_JR, BR_JALR
  } branch_e;

  // Cause register exception codes
  typedef enum logic [3:0] {
    EXC_RI = 4'd10,
    EXC_OV = 4'd12
  } excode_e;

endpackage
